// File: Bender.yml
package:
  name: matmul_tiles

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/matmul_pkg.sv
      - verilog/tile_fetch.sv
      - verilog/tile_mac.sv
      - verilog/result_writer.sv
      - verilog/matmul_tiles.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_matmul_tiles.sv

// File: list.f
+incdir+verilog
verilog/matmul_pkg.sv
verilog/tile_fetch.sv
verilog/tile_mac.sv
verilog/result_writer.sv
verilog/matmul_tiles.sv
testbench/tb_matmul_tiles.sv

// File: testbench/tb_matmul_tiles.sv
`include "matmul_defines.svh"

module tb_matmul_tiles;

    localparam int RESET_CYCLES = 10;
    localparam int NUM_RANDOM_JOBS = 12;
    localparam int MAX_TILES = 64;
    localparam int CYCLES_PER_TILE = 40;
    localparam int WATCHDOG_CYCLES = NUM_RANDOM_JOBS * MAX_TILES * CYCLES_PER_TILE;

    logic clk;
    logic reset;
    logic start;
    matmul_pkg::dim_t rows, middle, cols;
    matmul_pkg::addr_t rd_addr_a, rd_addr_b, wr_addr;
    matmul_pkg::data_t rd_data_a, rd_data_b, wr_data;
    logic wr_en, idle, done;

    matmul_pkg::data_t mem [4096];
    matmul_pkg::addr_t exp_addr [$];
    integer seed;
    int write_count;
    int done_count;
    string test_name;

    matmul_tiles dut0 (
        .clk(clk), .reset(reset), .start(start),
        .rows(rows), .middle(middle), .cols(cols),
        .rd_addr_a(rd_addr_a), .rd_data_a(rd_data_a),
        .rd_addr_b(rd_addr_b), .rd_data_b(rd_data_b),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .idle(idle), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // dual-ported memory with one cycle read latency
    always @(posedge clk) begin
        rd_data_a <= mem[rd_addr_a];
        rd_data_b <= mem[rd_addr_b];
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // write and done monitor sampled mid-cycle
    always @(negedge clk) begin : write_monitor
        matmul_pkg::addr_t next_addr;
        if (reset && wr_en) begin
            if (exp_addr.size() == 0) begin
                report_failure($sformatf("%s: write to %h when no write was due",
                                         test_name, wr_addr));
            end
            next_addr = exp_addr.pop_front();
            compare_addr({test_name, " write address"}, next_addr, wr_addr);
            write_count++;
        end
        if (reset && done) begin
            done_count++;
        end
    end

    initial begin
        repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
        report_failure($sformatf("timeout: the run did not finish within %0d cycles",
                                 WATCHDOG_CYCLES));
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_data(input string name, input matmul_pkg::data_t expected,
                                input matmul_pkg::data_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic compare_addr(input string name, input matmul_pkg::addr_t expected,
                                input matmul_pkg::addr_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic compare_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            report_failure($sformatf("error %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    ////////////////////////////////////////
    // stimulus and model
    ////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // preset value that differs for every address
    function automatic matmul_pkg::data_t fill_word(input int addr);
        return matmul_pkg::data_t'(addr * 32'h2545f491) ^ 32'h6b0c_0000;
    endfunction

    function automatic int rand_dim(input bit force_odd);
        int v;
        v = $unsigned($random(seed)) % 8;
        if (force_odd) begin
            return 2 * (v % 4) + 1;
        end
        return v + 1;
    endfunction

    task automatic run_job(input string name, input int r, input int m, input int c,
                           input bit busy_start, input bit settle);
        matmul_pkg::data_t exp_c [64];
        matmul_pkg::data_t acc;
        int row;
        int col;
        while (!idle) begin
            next_cycle();
        end
        test_name = name;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = fill_word(i);
        end
        for (int i = 0; i < r * m; i++) begin
            mem[`MM_A_BASE + i] = $random(seed);
        end
        for (int i = 0; i < m * c; i++) begin
            mem[`MM_B_BASE + i] = $random(seed);
        end
        for (int i = 0; i < r; i++) begin
            for (int j = 0; j < c; j++) begin
                acc = '0;
                for (int k = 0; k < m; k++) begin
                    acc = acc + mem[`MM_A_BASE + i * m + k] * mem[`MM_B_BASE + k * c + j];
                end
                exp_c[i * c + j] = acc;
            end
        end
        // tiles row by row in element order 11 12 21 22 without padding
        exp_addr = {};
        for (int tr = 0; tr < r; tr += 2) begin
            for (int tc = 0; tc < c; tc += 2) begin
                for (int e = 0; e < 4; e++) begin
                    row = tr + e / 2;
                    col = tc + e % 2;
                    if (row < r && col < c) begin
                        exp_addr.push_back(matmul_pkg::addr_t'(`MM_C_BASE + row * c + col));
                    end
                end
            end
        end
        write_count = 0;
        done_count = 0;
        rows = matmul_pkg::dim_t'(r);
        middle = matmul_pkg::dim_t'(m);
        cols = matmul_pkg::dim_t'(c);
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        if (busy_start) begin
            repeat (2) next_cycle();
            compare_count({name, " idle while busy"}, 0, int'(idle));
            start = 1'b1;
            next_cycle();
            start = 1'b0;
        end
        while (done_count == 0) begin
            next_cycle();
        end
        if (settle) begin
            repeat (6) next_cycle();
        end
        compare_count({name, " idle after done"}, 1, int'(idle));
        compare_count({name, " done pulses"}, 1, done_count);
        compare_count({name, " write count"}, r * c, write_count);
        compare_count({name, " writes missing"}, 0, exp_addr.size());
        for (int i = 0; i < r * c; i++) begin
            compare_data($sformatf("%s c[%0d]", name, i), exp_c[i], mem[`MM_C_BASE + i]);
        end
        for (int i = 0; i < 4; i++) begin
            compare_data($sformatf("%s word past c +%0d", name, i),
                         fill_word(`MM_C_BASE + r * c + i), mem[`MM_C_BASE + r * c + i]);
        end
    endtask

    initial begin
        int r;
        int m;
        int c;
        seed = 32'h54d3;
        test_name = "reset";
        reset = 1'b0;
        start = 1'b0;
        rows = 1;
        middle = 1;
        cols = 1;
        rd_data_a = '0;
        rd_data_b = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b1;
        compare_count("idle after reset", 1, int'(idle));
        compare_count("wr_en after reset", 0, int'(wr_en));
        compare_count("done after reset", 0, int'(done));
        compare_addr("rd_addr_a after reset", '0, rd_addr_a);
        compare_addr("rd_addr_b after reset", '0, rd_addr_b);
        next_cycle();

        for (int j = 0; j < NUM_RANDOM_JOBS; j++) begin
            r = rand_dim(j % 3 == 0);
            m = rand_dim(j % 3 == 0);
            c = rand_dim(j % 3 == 0);
            run_job($sformatf("random job %0d (%0dx%0dx%0d)", j, r, m, c), r, m, c,
                    j % 4 == 3, 1'b1);
        end

        // edge cases
        run_job("job 1x1x1", 1, 1, 1, 1'b0, 1'b1);
        run_job("job middle 1", 5, 1, 6, 1'b1, 1'b1);
        run_job("back to back first", 7, 3, 5, 1'b0, 1'b0);
        run_job("back to back second", 2, 6, 3, 1'b0, 1'b1);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: verilog/matmul_defines.svh
`ifndef MATMUL_DEFINES_SVH
`define MATMUL_DEFINES_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////

`define MM_DATA_WIDTH 32
`define MM_ADDR_WIDTH 12
`define MM_DIM_WIDTH 7

////////////////////////////////////////
// memory map, all matrices row-major
////////////////////////////////////////

`define MM_A_BASE 2
`define MM_B_BASE 1026
`define MM_C_BASE 2050

// tile slots in the result writer
`define MM_WRITE_CREDITS 2

// slice entry to partial product add
`define MM_MAC_LATENCY 2

`endif

// File: verilog/matmul_pkg.sv
`include "matmul_defines.svh"

package matmul_pkg;

    typedef logic [`MM_DATA_WIDTH-1:0] data_t;
    typedef logic [`MM_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`MM_DIM_WIDTH-1:0] dim_t;

    // elements 11, 12, 21, 22 from the msb down
    typedef logic [4*`MM_DATA_WIDTH-1:0] tile_t;
    typedef logic [3:0] mask_t;
    typedef logic [1:0] credit_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_READ,
        FETCH_EMIT,
        FETCH_WAIT_CREDIT
    } fetch_state_e;

    typedef enum logic {
        WRITER_EMPTY,
        WRITER_WRITING
    } writer_state_e;

endpackage

// File: verilog/matmul_tiles.sv
module matmul_tiles (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  matmul_pkg::dim_t  rows,
    input  matmul_pkg::dim_t  middle,
    input  matmul_pkg::dim_t  cols,
    output matmul_pkg::addr_t rd_addr_a,
    input  matmul_pkg::data_t rd_data_a,
    output matmul_pkg::addr_t rd_addr_b,
    input  matmul_pkg::data_t rd_data_b,
    output logic              wr_en,
    output matmul_pkg::addr_t wr_addr,
    output matmul_pkg::data_t wr_data,
    output logic              idle,
    output logic              done
);

    // fetch to mac
    logic slice_valid;
    matmul_pkg::tile_t slice_a, slice_b;
    matmul_pkg::dim_t slice_row, slice_col;
    logic last_slice, slice_last_tile;
    matmul_pkg::mask_t slice_mask;

    // mac to writer
    logic tile_valid;
    matmul_pkg::tile_t tile_sum;
    matmul_pkg::dim_t tile_row, tile_col;
    matmul_pkg::mask_t tile_mask;
    logic tile_last;

    // writer back to fetch
    logic credit_return;

    tile_fetch fetch0 (
        .clk(clk), .reset(reset), .start(start),
        .rows(rows), .middle(middle), .cols(cols),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .credit_return(credit_return),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .slice_valid(slice_valid), .slice_a(slice_a), .slice_b(slice_b),
        .tile_row(slice_row), .tile_col(slice_col),
        .last_slice(last_slice), .last_tile(slice_last_tile),
        .wr_mask(slice_mask), .idle(idle)
    );

    tile_mac mac0 (
        .clk(clk), .reset(reset),
        .slice_valid(slice_valid), .slice_a(slice_a), .slice_b(slice_b),
        .tile_row_in(slice_row), .tile_col_in(slice_col),
        .last_slice(last_slice), .last_tile_in(slice_last_tile), .wr_mask_in(slice_mask),
        .tile_valid(tile_valid), .tile_sum(tile_sum),
        .tile_row(tile_row), .tile_col(tile_col),
        .wr_mask(tile_mask), .last_tile(tile_last)
    );

    result_writer writer0 (
        .clk(clk), .reset(reset), .cols(cols),
        .tile_valid(tile_valid), .tile_sum(tile_sum),
        .tile_row(tile_row), .tile_col(tile_col),
        .wr_mask(tile_mask), .last_tile(tile_last),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .credit_return(credit_return), .done(done)
    );

endmodule

// File: verilog/result_writer.sv
`include "matmul_defines.svh"

module result_writer (
    input  logic              clk,
    input  logic              reset,
    input  matmul_pkg::dim_t  cols,
    input  logic              tile_valid,
    input  matmul_pkg::tile_t tile_sum,
    input  matmul_pkg::dim_t  tile_row,
    input  matmul_pkg::dim_t  tile_col,
    input  matmul_pkg::mask_t wr_mask,
    input  logic              last_tile,
    output logic              wr_en,
    output matmul_pkg::addr_t wr_addr,
    output matmul_pkg::data_t wr_data,
    output logic              credit_return,
    output logic              done
);

    localparam int W = `MM_DATA_WIDTH;

    matmul_pkg::writer_state_e state;
    logic [1:0] elem;
    logic [1:0] count;
    logic wr_ptr, rd_ptr;
    logic tile_done;
    logic pop;

    // two-entry tile buffer
    matmul_pkg::tile_t hold_sum [2];
    matmul_pkg::dim_t hold_row [2];
    matmul_pkg::dim_t hold_col [2];
    matmul_pkg::mask_t hold_mask [2];
    logic hold_last [2];

    matmul_pkg::addr_t elem_row, elem_col;

    assign pop = (state == matmul_pkg::WRITER_WRITING) && (elem == 2'd3);

    always_comb begin
        elem_row = matmul_pkg::addr_t'(hold_row[rd_ptr]) + matmul_pkg::addr_t'(elem[1]);
        elem_col = matmul_pkg::addr_t'(hold_col[rd_ptr]) + matmul_pkg::addr_t'(elem[0]);
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= matmul_pkg::WRITER_EMPTY;
            elem <= '0;
            count <= '0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            wr_en <= 1'b0;
            credit_return <= 1'b0;
            tile_done <= 1'b0;
            done <= 1'b0;
        end else begin
            count <= count + 2'(tile_valid) - 2'(pop);
            if (tile_valid) begin
                wr_ptr <= ~wr_ptr;
            end
            wr_en <= (state == matmul_pkg::WRITER_WRITING) && hold_mask[rd_ptr][3 - elem];
            credit_return <= pop;
            tile_done <= pop && hold_last[rd_ptr];
            done <= tile_done;
            case (state)
                matmul_pkg::WRITER_EMPTY: begin
                    if (tile_valid) begin
                        state <= matmul_pkg::WRITER_WRITING;
                    end
                end
                default: begin
                    elem <= elem + 2'd1;
                    if (pop) begin
                        rd_ptr <= ~rd_ptr;
                        if (count == 2'd1 && !tile_valid) begin
                            state <= matmul_pkg::WRITER_EMPTY;
                        end
                    end
                end
            endcase
        end
    end

    // element order 11, 12, 21, 22
    always_ff @(posedge clk) begin
        if (tile_valid) begin
            hold_sum[wr_ptr] <= tile_sum;
            hold_row[wr_ptr] <= tile_row;
            hold_col[wr_ptr] <= tile_col;
            hold_mask[wr_ptr] <= wr_mask;
            hold_last[wr_ptr] <= last_tile;
        end
        if (state == matmul_pkg::WRITER_WRITING) begin
            wr_addr <= matmul_pkg::addr_t'(`MM_C_BASE) + elem_row * matmul_pkg::addr_t'(cols)
                     + elem_col;
            wr_data <= hold_sum[rd_ptr][(3 - elem) * W +: W];
        end
    end

endmodule

// File: verilog/tile_fetch.sv
`include "matmul_defines.svh"

module tile_fetch (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  matmul_pkg::dim_t  rows,
    input  matmul_pkg::dim_t  middle,
    input  matmul_pkg::dim_t  cols,
    input  matmul_pkg::data_t rd_data_a,
    input  matmul_pkg::data_t rd_data_b,
    input  logic              credit_return,
    output matmul_pkg::addr_t rd_addr_a,
    output matmul_pkg::addr_t rd_addr_b,
    output logic              slice_valid,
    output matmul_pkg::tile_t slice_a,
    output matmul_pkg::tile_t slice_b,
    output matmul_pkg::dim_t  tile_row,
    output matmul_pkg::dim_t  tile_col,
    output logic              last_slice,
    output logic              last_tile,
    output matmul_pkg::mask_t wr_mask,
    output logic              idle
);

    localparam int W = `MM_DATA_WIDTH;

    matmul_pkg::fetch_state_e state;
    matmul_pkg::credit_t credits;
    matmul_pkg::dim_t rows_q, mid_q, cols_q;
    matmul_pkg::dim_t row_q, col_q, k_q;
    logic [1:0] rd_idx;

    // read on the address bus, then its data on the read bus
    logic iss_valid, cap_valid;
    logic [1:0] iss_idx, cap_idx;
    logic iss_pad_a, iss_pad_b, cap_pad_a, cap_pad_b;

    matmul_pkg::addr_t a_row, a_k, b_k, b_col;
    logic pad_a, pad_b;
    logic last_k, last_c, last_r, col_pair, row_pair;
    logic issuing, spend;

    assign issuing = (state == matmul_pkg::FETCH_READ) || (state == matmul_pkg::FETCH_EMIT);
    assign last_k = (mid_q - k_q) <= matmul_pkg::dim_t'(2);
    assign last_c = (cols_q - col_q) <= matmul_pkg::dim_t'(2);
    assign last_r = (rows_q - row_q) <= matmul_pkg::dim_t'(2);
    assign col_pair = (cols_q - col_q) >= matmul_pkg::dim_t'(2);
    assign row_pair = (rows_q - row_q) >= matmul_pkg::dim_t'(2);
    assign idle = (state == matmul_pkg::FETCH_IDLE)
               && (credits == matmul_pkg::credit_t'(`MM_WRITE_CREDITS));

    // a credit goes with the first slice of each tile
    always_comb begin
        case (state)
            matmul_pkg::FETCH_IDLE:        spend = start && idle;
            matmul_pkg::FETCH_EMIT:        spend = last_k && !(last_c && last_r) && (credits != '0);
            matmul_pkg::FETCH_WAIT_CREDIT: spend = credits != '0;
            default:                       spend = 1'b0;
        endcase
    end

    // element position for read rd_idx, order 11 12 21 22
    always_comb begin
        a_row = matmul_pkg::addr_t'(row_q) + matmul_pkg::addr_t'(rd_idx[1]);
        a_k   = matmul_pkg::addr_t'(k_q) + matmul_pkg::addr_t'(rd_idx[0]);
        b_k   = matmul_pkg::addr_t'(k_q) + matmul_pkg::addr_t'(rd_idx[1]);
        b_col = matmul_pkg::addr_t'(col_q) + matmul_pkg::addr_t'(rd_idx[0]);
        pad_a = (a_row >= matmul_pkg::addr_t'(rows_q)) || (a_k >= matmul_pkg::addr_t'(mid_q));
        pad_b = (b_k >= matmul_pkg::addr_t'(mid_q)) || (b_col >= matmul_pkg::addr_t'(cols_q));
    end

    ////////////////////////////////////////
    // walk k, then tile column, then tile row
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= matmul_pkg::FETCH_IDLE;
            credits <= matmul_pkg::credit_t'(`MM_WRITE_CREDITS);
            rows_q <= '0;
            mid_q <= '0;
            cols_q <= '0;
            row_q <= '0;
            col_q <= '0;
            k_q <= '0;
            rd_idx <= '0;
        end else begin
            credits <= credits + matmul_pkg::credit_t'(credit_return)
                     - matmul_pkg::credit_t'(spend);
            if (issuing) begin
                rd_idx <= rd_idx + 2'd1;
            end
            case (state)
                matmul_pkg::FETCH_IDLE: begin
                    if (spend) begin
                        rows_q <= rows;
                        mid_q <= middle;
                        cols_q <= cols;
                        row_q <= '0;
                        col_q <= '0;
                        k_q <= '0;
                        state <= matmul_pkg::FETCH_READ;
                    end
                end
                matmul_pkg::FETCH_READ: begin
                    if (rd_idx == 2'd2) begin
                        state <= matmul_pkg::FETCH_EMIT;
                    end
                end
                matmul_pkg::FETCH_EMIT: begin
                    if (!last_k) begin
                        k_q <= k_q + matmul_pkg::dim_t'(2);
                    end else if (!last_c) begin
                        k_q <= '0;
                        col_q <= col_q + matmul_pkg::dim_t'(2);
                    end else begin
                        k_q <= '0;
                        col_q <= '0;
                        row_q <= row_q + matmul_pkg::dim_t'(2);
                    end
                    if (last_k && last_c && last_r) begin
                        state <= matmul_pkg::FETCH_IDLE;
                    end else if (!last_k || spend) begin
                        state <= matmul_pkg::FETCH_READ;
                    end else begin
                        state <= matmul_pkg::FETCH_WAIT_CREDIT;
                    end
                end
                default: begin
                    if (spend) begin
                        state <= matmul_pkg::FETCH_READ;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_addr_a <= '0;
            rd_addr_b <= '0;
            iss_valid <= 1'b0;
            cap_valid <= 1'b0;
            slice_valid <= 1'b0;
            iss_idx <= '0;
            cap_idx <= '0;
            iss_pad_a <= 1'b0;
            iss_pad_b <= 1'b0;
            cap_pad_a <= 1'b0;
            cap_pad_b <= 1'b0;
        end else begin
            iss_valid <= issuing;
            cap_valid <= iss_valid;
            cap_idx <= iss_idx;
            cap_pad_a <= iss_pad_a;
            cap_pad_b <= iss_pad_b;
            slice_valid <= cap_valid && (cap_idx == 2'd3);
            if (issuing) begin
                rd_addr_a <= matmul_pkg::addr_t'(`MM_A_BASE) + a_row * matmul_pkg::addr_t'(mid_q) + a_k;
                rd_addr_b <= matmul_pkg::addr_t'(`MM_B_BASE) + b_k * matmul_pkg::addr_t'(cols_q) + b_col;
                iss_idx <= rd_idx;
                iss_pad_a <= pad_a;
                iss_pad_b <= pad_b;
            end
        end
    end

    // operands and sidecar, stable through the slice_valid cycle
    always_ff @(posedge clk) begin
        if (cap_valid) begin
            slice_a[(3 - cap_idx) * W +: W] <= cap_pad_a ? '0 : rd_data_a;
            slice_b[(3 - cap_idx) * W +: W] <= cap_pad_b ? '0 : rd_data_b;
        end
        if (state == matmul_pkg::FETCH_EMIT) begin
            tile_row <= row_q;
            tile_col <= col_q;
            last_slice <= last_k;
            last_tile <= last_k && last_c && last_r;
            if (k_q == '0) begin
                wr_mask <= {1'b1, col_pair, row_pair, col_pair && row_pair};
            end
        end
    end

endmodule

// File: verilog/tile_mac.sv
`include "matmul_defines.svh"

module tile_mac (
    input  logic              clk,
    input  logic              reset,
    input  logic              slice_valid,
    input  matmul_pkg::tile_t slice_a,
    input  matmul_pkg::tile_t slice_b,
    input  matmul_pkg::dim_t  tile_row_in,
    input  matmul_pkg::dim_t  tile_col_in,
    input  logic              last_slice,
    input  logic              last_tile_in,
    input  matmul_pkg::mask_t wr_mask_in,
    output logic              tile_valid,
    output matmul_pkg::tile_t tile_sum,
    output matmul_pkg::dim_t  tile_row,
    output matmul_pkg::dim_t  tile_col,
    output matmul_pkg::mask_t wr_mask,
    output logic              last_tile
);

    localparam int W = `MM_DATA_WIDTH;
    localparam int LAT = `MM_MAC_LATENCY;

    matmul_pkg::data_t a [4];
    matmul_pkg::data_t b [4];
    matmul_pkg::data_t prod_q [8];
    matmul_pkg::tile_t psum_q;
    logic fresh;

    // sidecar runs next to the product stages
    logic valid_sr [LAT];
    logic last_slice_sr [LAT];
    logic last_tile_sr [LAT];
    matmul_pkg::dim_t row_sr [LAT];
    matmul_pkg::dim_t col_sr [LAT];
    matmul_pkg::mask_t mask_sr [LAT];

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            a[i] = slice_a[(3 - i) * W +: W];
            b[i] = slice_b[(3 - i) * W +: W];
        end
    end

    ////////////////////////////////////////
    // products, then 2x2 sums
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (slice_valid) begin
            // pairs feeding c11, c12, c21, c22
            prod_q[0] <= a[0] * b[0];
            prod_q[1] <= a[1] * b[2];
            prod_q[2] <= a[0] * b[1];
            prod_q[3] <= a[1] * b[3];
            prod_q[4] <= a[2] * b[0];
            prod_q[5] <= a[3] * b[2];
            prod_q[6] <= a[2] * b[1];
            prod_q[7] <= a[3] * b[3];
        end
        if (valid_sr[0]) begin
            psum_q <= {prod_q[0] + prod_q[1], prod_q[2] + prod_q[3],
                       prod_q[4] + prod_q[5], prod_q[6] + prod_q[7]};
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < LAT; i++) begin
                valid_sr[i] <= 1'b0;
            end
            fresh <= 1'b1;
            tile_valid <= 1'b0;
        end else begin
            valid_sr[0] <= slice_valid;
            for (int i = 1; i < LAT; i++) begin
                valid_sr[i] <= valid_sr[i-1];
            end
            tile_valid <= valid_sr[LAT-1] && last_slice_sr[LAT-1];
            // next slice after a tile's last starts a new sum
            if (valid_sr[LAT-1]) begin
                fresh <= last_slice_sr[LAT-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        last_slice_sr[0] <= last_slice;
        last_tile_sr[0] <= last_tile_in;
        row_sr[0] <= tile_row_in;
        col_sr[0] <= tile_col_in;
        mask_sr[0] <= wr_mask_in;
        for (int i = 1; i < LAT; i++) begin
            last_slice_sr[i] <= last_slice_sr[i-1];
            last_tile_sr[i] <= last_tile_sr[i-1];
            row_sr[i] <= row_sr[i-1];
            col_sr[i] <= col_sr[i-1];
            mask_sr[i] <= mask_sr[i-1];
        end
        if (valid_sr[LAT-1]) begin
            for (int i = 0; i < 4; i++) begin
                tile_sum[i * W +: W] <= fresh ? psum_q[i * W +: W]
                                              : tile_sum[i * W +: W] + psum_q[i * W +: W];
            end
            tile_row <= row_sr[LAT-1];
            tile_col <= col_sr[LAT-1];
            wr_mask <= mask_sr[LAT-1];
            last_tile <= last_tile_sr[LAT-1];
        end
    end

endmodule
